/* hw/ioTypesPkg.sv */
package ioTypesPkg;

  // Bus side
  typedef logic [31:0] busAddrT;
  typedef logic [31:0] busDataT;

  // One bit per push button
  typedef logic [3:0] keyBitsT;

  // One bit per red LED
  typedef logic [9:0] ledBitsT;

  // Six display digits, digit 0 in the low nibble
  typedef logic [23:0] hexDataT;

  // Active-low segments, bit 6 is g and bit 0 is a
  typedef logic [6:0] segT;

  // Interrupting device number
  typedef logic [3:0] devIdT;

endpackage

/* hw/ioMapPkg.sv */
package ioMapPkg;

  // ============================================================
  // Bus address map
  // ============================================================
  localparam logic [31:0] hexAddr      = 32'hFFFFF000;
  localparam logic [31:0] ledAddr      = 32'hFFFFF020;
  localparam logic [31:0] keyDataAddr  = 32'hFFFFF080;
  localparam logic [31:0] keyCtlAddr   = 32'hFFFFF084;
  localparam logic [31:0] timerCntAddr = 32'hFFFFF100;
  localparam logic [31:0] timerLimAddr = 32'hFFFFF104;
  localparam logic [31:0] timerCtlAddr = 32'hFFFFF108;

  // ============================================================
  // Control register layout, shared by timer and keys
  // ============================================================
  localparam int readyBit    = 0;
  localparam int overflowBit = 1;
  localparam int intEnBit    = 4;

  // Interrupt device numbers, lower number wins
  localparam logic [3:0] timerDevId = 4'd1;
  localparam logic [3:0] keyDevId   = 4'd2;
  // Reported when nobody is requesting
  localparam logic [3:0] noDevId    = 4'd15;

endpackage

/* hw/ioFabric.sv */
`timescale 1ns/1ps

module ioFabric
  import ioTypesPkg::*, ioMapPkg::*;
#(
  parameter int numKeys = 4
) (
  input  busAddrT addr,
  input  logic    wrEn,
  input  logic    rdEn,
  output logic    timerCntWr,
  output logic    timerLimWr,
  output logic    timerCtlWr,
  output logic    timerCntRd,
  output logic    timerLimRd,
  output logic    keyDataRd,
  output logic    keyCtlWr,
  output logic    ledWr,
  output logic    hexWr,
  input  busDataT timerCnt,
  input  busDataT timerLim,
  input  busDataT timerCtl,
  input  keyBitsT keyData,
  input  busDataT keyCtl,
  input  ledBitsT ledData,
  input  hexDataT hexData,
  input  logic    timerIntr,
  input  logic    keyIntr,
  output busDataT rdData,
  output logic    irq,
  output devIdT   intId
);

  logic timerCtlRd;
  logic keyCtlRd;
  logic ledRd;
  logic hexRd;

  // ============================================================
  // Address decode
  // ============================================================
  assign hexWr      = wrEn && (addr == hexAddr);
  assign ledWr      = wrEn && (addr == ledAddr);
  assign keyCtlWr   = wrEn && (addr == keyCtlAddr);
  assign timerCntWr = wrEn && (addr == timerCntAddr);
  assign timerLimWr = wrEn && (addr == timerLimAddr);
  assign timerCtlWr = wrEn && (addr == timerCtlAddr);

  assign hexRd      = rdEn && (addr == hexAddr);
  assign ledRd      = rdEn && (addr == ledAddr);
  assign keyDataRd  = rdEn && (addr == keyDataAddr);
  assign keyCtlRd   = rdEn && (addr == keyCtlAddr);
  assign timerCntRd = rdEn && (addr == timerCntAddr);
  assign timerLimRd = rdEn && (addr == timerLimAddr);
  assign timerCtlRd = rdEn && (addr == timerCtlAddr);

  // Read mux, zero when nothing is selected
  always_comb begin
    rdData = '0;
    if (hexRd) begin
      rdData = busDataT'(hexData);
    end else if (ledRd) begin
      rdData = busDataT'(ledData);
    end else if (keyDataRd) begin
      rdData = busDataT'(keyData[numKeys-1:0]);
    end else if (keyCtlRd) begin
      rdData = keyCtl;
    end else if (timerCntRd) begin
      rdData = timerCnt;
    end else if (timerLimRd) begin
      rdData = timerLim;
    end else if (timerCtlRd) begin
      rdData = timerCtl;
    end
  end

  // Fixed priority, timer ahead of keys
  assign irq   = timerIntr || keyIntr;
  assign intId = timerIntr ? timerDevId :
                 keyIntr   ? keyDevId   :
                             noDevId;

endmodule

/* hw/intervalTimer.sv */
`timescale 1ns/1ps

module intervalTimer
  import ioTypesPkg::*, ioMapPkg::*;
(
  input  logic    clk,
  input  logic    RESET,
  input  busDataT wrData,
  input  logic    cntWr,
  input  logic    limWr,
  input  logic    ctlWr,
  input  logic    cntRd,
  input  logic    limRd,
  output busDataT cnt,
  output busDataT lim,
  output busDataT ctl,
  output logic    intr
);

  logic ready;
  logic overflow;
  logic intEn;
  logic atLimit;
  logic wrapEv;

  // Last count before the wrap, only with a nonzero limit
  assign atLimit = (lim != '0) && (cnt == lim - 1'b1);
  // A counter write takes the edge away from the wrap
  assign wrapEv  = atLimit && !cntWr;

  // ============================================================
  // Count and limit
  // ============================================================
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      cnt <= '0;
    end else if (cntWr) begin
      cnt <= wrData;
    end else if (atLimit) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      lim <= '0;
    end else if (limWr) begin
      lim <= wrData;
    end
  end

  // ============================================================
  // Status and interrupt enable
  // ============================================================
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      ready    <= 1'b0;
      overflow <= 1'b0;
      intEn    <= 1'b0;
    end else begin
      // Reading count or limit acknowledges the wrap
      if (cntRd || limRd) begin
        ready <= 1'b0;
      end
      if (ctlWr) begin
        if (!wrData[readyBit]) ready <= 1'b0;
        if (!wrData[overflowBit]) overflow <= 1'b0;
        intEn <= wrData[intEnBit];
      end
      // New wrap wins over any clear in the same cycle
      if (wrapEv) begin
        ready <= 1'b1;
        if (ready) begin
          overflow <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    ctl              = '0;
    ctl[readyBit]    = ready;
    ctl[overflowBit] = overflow;
    ctl[intEnBit]    = intEn;
  end

  assign intr = ready && intEn;

endmodule

/* hw/keyDebouncer.sv */
`timescale 1ns/1ps

module keyDebouncer
  import ioTypesPkg::*, ioMapPkg::*;
#(
  parameter int samplePeriod = 16,
  parameter int numKeys      = 4
) (
  input  logic    clk,
  input  logic    RESET,
  input  keyBitsT keyN,
  input  busDataT wrData,
  input  logic    dataRd,
  input  logic    ctlWr,
  output keyBitsT keyData,
  output busDataT keyCtl,
  output logic    intr
);

  localparam int tickW = (samplePeriod > 1) ? $clog2(samplePeriod) : 1;

  // Only the populated buttons take part
  localparam keyBitsT keyMask = keyBitsT'((1 << numKeys) - 1);

  logic [tickW-1:0] tickCnt;
  logic             tick;
  keyBitsT          sample;
  keyBitsT          lastSample;
  logic             accept;
  logic             ready;
  logic             overflow;
  logic             intEn;

  // ============================================================
  // Sample tick
  // ============================================================
  assign tick = (tickCnt == tickW'(samplePeriod - 1));

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      tickCnt <= '0;
    end else if (tick) begin
      tickCnt <= '0;
    end else begin
      tickCnt <= tickCnt + 1'b1;
    end
  end

  // Two equal samples that differ from the stored value
  assign accept = tick && (sample == lastSample) && (sample != keyData);

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      sample     <= '0;
      lastSample <= '0;
      keyData    <= '0;
    end else if (tick) begin
      // Keys are active low, store pressed as 1
      sample     <= ~keyN & keyMask;
      lastSample <= sample;
      if (accept) begin
        keyData <= sample;
      end
    end
  end

  // ============================================================
  // Status and interrupt enable
  // ============================================================
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      ready    <= 1'b0;
      overflow <= 1'b0;
      intEn    <= 1'b0;
    end else begin
      if (dataRd) begin
        ready <= 1'b0;
      end
      if (ctlWr) begin
        if (!wrData[readyBit]) ready <= 1'b0;
        if (!wrData[overflowBit]) overflow <= 1'b0;
        intEn <= wrData[intEnBit];
      end
      // Unread change still pending means one was lost
      if (accept) begin
        ready <= 1'b1;
        if (ready) begin
          overflow <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    keyCtl              = '0;
    keyCtl[readyBit]    = ready;
    keyCtl[overflowBit] = overflow;
    keyCtl[intEnBit]    = intEn;
  end

  assign intr = ready && intEn;

endmodule

/* hw/displayRegs.sv */
`timescale 1ns/1ps

module displayRegs
  import ioTypesPkg::*;
(
  input  logic    clk,
  input  logic    RESET,
  input  busDataT wrData,
  input  logic    ledWr,
  input  logic    hexWr,
  output ledBitsT ledData,
  output hexDataT hexData,
  output ledBitsT ledr,
  output segT     hex0,
  output segT     hex1,
  output segT     hex2,
  output segT     hex3,
  output segT     hex4,
  output segT     hex5
);

  // Hex digit to active-low segments
  function automatic segT segDecode(input logic [3:0] digit);
    case (digit)
      4'h0:    segDecode = 7'b1000000;
      4'h1:    segDecode = 7'b1111001;
      4'h2:    segDecode = 7'b0100100;
      4'h3:    segDecode = 7'b0110000;
      4'h4:    segDecode = 7'b0011001;
      4'h5:    segDecode = 7'b0010010;
      4'h6:    segDecode = 7'b0000010;
      4'h7:    segDecode = 7'b1111000;
      4'h8:    segDecode = 7'b0000000;
      4'h9:    segDecode = 7'b0010000;
      4'hA:    segDecode = 7'b0001000;
      4'hB:    segDecode = 7'b0000011;
      4'hC:    segDecode = 7'b1000110;
      4'hD:    segDecode = 7'b0100001;
      4'hE:    segDecode = 7'b0000110;
      default: segDecode = 7'b0001110;
    endcase
  endfunction

  // ============================================================
  // Output registers
  // ============================================================
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      ledData <= '0;
      hexData <= 24'hFFFFFF;
    end else begin
      if (ledWr) ledData <= ledBitsT'(wrData);
      if (hexWr) hexData <= hexDataT'(wrData);
    end
  end

  assign ledr = ledData;

  // Digit 0 is the low nibble
  assign hex0 = segDecode(hexData[3:0]);
  assign hex1 = segDecode(hexData[7:4]);
  assign hex2 = segDecode(hexData[11:8]);
  assign hex3 = segDecode(hexData[15:12]);
  assign hex4 = segDecode(hexData[19:16]);
  assign hex5 = segDecode(hexData[23:20]);

endmodule

/* hw/ioSubsystem.sv */
`timescale 1ns/1ps

module ioSubsystem
  import ioTypesPkg::*;
#(
  parameter int samplePeriod = 16,
  parameter int numKeys      = 4
) (
  input  logic    clk,
  input  logic    RESET,
  input  busAddrT addr,
  input  busDataT wrData,
  input  logic    wrEn,
  input  logic    rdEn,
  output busDataT rdData,
  input  keyBitsT keyN,
  output ledBitsT ledr,
  output segT     hex0,
  output segT     hex1,
  output segT     hex2,
  output segT     hex3,
  output segT     hex4,
  output segT     hex5,
  output logic    irq,
  output devIdT   intId
);

  // Strobes from the fabric
  logic timerCntWr;
  logic timerLimWr;
  logic timerCtlWr;
  logic timerCntRd;
  logic timerLimRd;
  logic keyDataRd;
  logic keyCtlWr;
  logic ledWr;
  logic hexWr;

  // Register values back to the fabric
  busDataT timerCnt;
  busDataT timerLim;
  busDataT timerCtl;
  keyBitsT keyData;
  busDataT keyCtl;
  ledBitsT ledData;
  hexDataT hexData;
  logic    timerIntr;
  logic    keyIntr;

  ioFabric #(
    .numKeys (numKeys)
  ) ioFabric_inst (
    .addr       (addr),
    .wrEn       (wrEn),
    .rdEn       (rdEn),
    .timerCntWr (timerCntWr),
    .timerLimWr (timerLimWr),
    .timerCtlWr (timerCtlWr),
    .timerCntRd (timerCntRd),
    .timerLimRd (timerLimRd),
    .keyDataRd  (keyDataRd),
    .keyCtlWr   (keyCtlWr),
    .ledWr      (ledWr),
    .hexWr      (hexWr),
    .timerCnt   (timerCnt),
    .timerLim   (timerLim),
    .timerCtl   (timerCtl),
    .keyData    (keyData),
    .keyCtl     (keyCtl),
    .ledData    (ledData),
    .hexData    (hexData),
    .timerIntr  (timerIntr),
    .keyIntr    (keyIntr),
    .rdData     (rdData),
    .irq        (irq),
    .intId      (intId)
  );

  intervalTimer intervalTimer_inst (
    .clk    (clk),
    .RESET  (RESET),
    .wrData (wrData),
    .cntWr  (timerCntWr),
    .limWr  (timerLimWr),
    .ctlWr  (timerCtlWr),
    .cntRd  (timerCntRd),
    .limRd  (timerLimRd),
    .cnt    (timerCnt),
    .lim    (timerLim),
    .ctl    (timerCtl),
    .intr   (timerIntr)
  );

  keyDebouncer #(
    .samplePeriod (samplePeriod),
    .numKeys      (numKeys)
  ) keyDebouncer_inst (
    .clk     (clk),
    .RESET   (RESET),
    .keyN    (keyN),
    .wrData  (wrData),
    .dataRd  (keyDataRd),
    .ctlWr   (keyCtlWr),
    .keyData (keyData),
    .keyCtl  (keyCtl),
    .intr    (keyIntr)
  );

  displayRegs displayRegs_inst (
    .clk     (clk),
    .RESET   (RESET),
    .wrData  (wrData),
    .ledWr   (ledWr),
    .hexWr   (hexWr),
    .ledData (ledData),
    .hexData (hexData),
    .ledr    (ledr),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

/* sim/tbTasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ============================================================
// Counters and random source
// ============================================================
int checkCount   = 0;
int errCount     = 0;
int timeoutCount = 0;

logic [31:0] lfsrState = 32'h5a2d;

// Active-low seven-segment patterns, gfedcba, digits 0 to F
localparam segT segTable [16] = '{
  7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
};

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] randBits(input int n);
  logic [31:0] v;
  logic        fb;
  v = '0;
  for (int i = 0; i < n; i++) begin
    fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    v         = {v[30:0], fb};
  end
  return v;
endfunction

// Called one time unit after a rising edge, returns at the same point
task automatic busWrite(input busAddrT a, input busDataT d);
  addr   = a;
  wrData = d;
  wrEn   = 1'b1;
  @(posedge clk);
  #1;
  wrEn   = 1'b0;
  addr   = '0;
  wrData = '0;
endtask

// rdData is sampled mid-cycle, well after the edge has settled
task automatic busRead(input busAddrT a, output busDataT d);
  addr = a;
  rdEn = 1'b1;
  #4;
  d = rdData;
  @(posedge clk);
  #1;
  rdEn = 1'b0;
  addr = '0;
endtask

task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
  checkCount++;
  assert (got === exp) else begin
    errCount++;
    $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic reportTimeout(input string what);
  errCount++;
  timeoutCount++;
  $display("Timed out at %0t ns waiting for %s", $time, what);
endtask

`endif

/* sim/ioSubsystemTb.sv */
`timescale 1ns/1ps

module ioSubsystemTb
  import ioTypesPkg::*, ioMapPkg::*;
;

  localparam int samplePeriod = 16;
  localparam int numKeys      = 4;

  logic    clk = 1'b0;
  logic    RESET;
  busAddrT addr;
  busDataT wrData;
  logic    wrEn;
  logic    rdEn;
  busDataT rdData;
  keyBitsT keyN;
  ledBitsT ledr;
  segT     hex0;
  segT     hex1;
  segT     hex2;
  segT     hex3;
  segT     hex4;
  segT     hex5;
  logic    irq;
  devIdT   intId;

  `include "tbTasks.svh"

  ioSubsystem #(
    .samplePeriod (samplePeriod),
    .numKeys      (numKeys)
  ) ioSubsystem_inst (
    .clk    (clk),
    .RESET  (RESET),
    .addr   (addr),
    .wrData (wrData),
    .wrEn   (wrEn),
    .rdEn   (rdEn),
    .rdData (rdData),
    .keyN   (keyN),
    .ledr   (ledr),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3),
    .hex4   (hex4),
    .hex5   (hex5),
    .irq    (irq),
    .intId  (intId)
  );

  always #4 clk = ~clk;

  // Polls a control register until the given bit is set
  task automatic waitCtlBit(input busAddrT a, input int bitPos, input int maxReads,
                            input string what);
    busDataT v;
    bit      seen;
    seen = 1'b0;
    for (int n = 0; n < maxReads && !seen; n++) begin
      busRead(a, v);
      seen = v[bitPos];
    end
    if (!seen) reportTimeout(what);
  endtask

  task automatic checkSegments(input hexDataT val);
    checkEq("hex0", hex0, segTable[val[3:0]]);
    checkEq("hex1", hex1, segTable[val[7:4]]);
    checkEq("hex2", hex2, segTable[val[11:8]]);
    checkEq("hex3", hex3, segTable[val[15:12]]);
    checkEq("hex4", hex4, segTable[val[19:16]]);
    checkEq("hex5", hex5, segTable[val[23:20]]);
  endtask

  initial begin
    busDataT rdVal;
    busDataT ledVal;
    busDataT hexVal;
    keyBitsT pressed;
    RESET  = 1'b1;
    addr   = '0;
    wrData = '0;
    wrEn   = 1'b0;
    rdEn   = 1'b0;
    keyN   = '1;
    repeat (3) @(posedge clk);
    #1;
    RESET = 1'b0;

    // ============================================================
    // Reset values
    // ============================================================
    busRead(hexAddr, rdVal);
    checkEq("hexData", rdVal, 32'h00FFFFFF);
    checkSegments(24'hFFFFFF);
    busRead(ledAddr, rdVal);
    checkEq("ledData", rdVal, 32'h0);
    checkEq("ledr", ledr, 32'h0);
    checkEq("irq", irq, 32'h0);
    checkEq("intId", intId, 32'd15);
    busRead(timerCtlAddr, rdVal);
    checkEq("timerCtl", rdVal, 32'h0);
    busRead(keyCtlAddr, rdVal);
    checkEq("keyCtl", rdVal, 32'h0);

    // ============================================================
    // LED and hex registers
    // ============================================================
    for (int i = 0; i < 6; i++) begin
      ledVal = randBits(32);
      hexVal = randBits(32);
      busWrite(ledAddr, ledVal);
      busWrite(hexAddr, hexVal);
      busRead(ledAddr, rdVal);
      checkEq("ledData", rdVal, ledVal & 32'h3FF);
      checkEq("ledr", ledr, ledVal & 32'h3FF);
      busRead(hexAddr, rdVal);
      checkEq("hexData", rdVal, hexVal & 32'hFFFFFF);
      checkSegments(hexVal[23:0]);
    end
    busRead(32'hFFFFF200, rdVal);
    checkEq("rdData unmapped", rdVal, 32'h0);

    // ============================================================
    // Timer status
    // ============================================================
    busWrite(timerLimAddr, 32'd20);
    busWrite(timerCntAddr, 32'd0);
    waitCtlBit(timerCtlAddr, 0, 40, "timer ready");
    busRead(timerCntAddr, rdVal);
    checkCount++;
    assert (rdVal < 32'd20) else begin
      errCount++;
      $display("[FAIL] %0t ns timerCnt got %0d expected below 20", $time, rdVal);
    end
    busRead(timerCtlAddr, rdVal);
    checkEq("timerCtl ready", rdVal[0], 32'h0);
    // Two more wraps without a count read
    waitCtlBit(timerCtlAddr, 1, 60, "timer overflow");
    busRead(timerCtlAddr, rdVal);
    checkEq("timerCtl", rdVal, 32'h3);
    busWrite(timerCtlAddr, 32'h0);
    busRead(timerCtlAddr, rdVal);
    checkEq("timerCtl", rdVal, 32'h0);

    // Timer interrupt
    busWrite(timerCtlAddr, 32'h13);
    waitCtlBit(timerCtlAddr, 0, 40, "timer ready with intEn");
    checkEq("irq", irq, 32'h1);
    checkEq("intId", intId, 32'd1);
    busWrite(timerCtlAddr, 32'h10);
    checkEq("irq", irq, 32'h0);
    checkEq("intId", intId, 32'd15);
    busWrite(timerCtlAddr, 32'h0);

    // ============================================================
    // Key debounce
    // ============================================================
    pressed = '0;
    for (int tries = 0; tries < 16 && pressed == '0; tries++) begin
      pressed = keyBitsT'(randBits(numKeys));
    end
    if (pressed == '0) pressed = 4'b0101;
    keyN = ~pressed;
    waitCtlBit(keyCtlAddr, 0, 3 * samplePeriod + 16, "key ready on press");
    busRead(keyDataAddr, rdVal);
    checkEq("keyData", rdVal, {28'h0, pressed});
    busRead(keyCtlAddr, rdVal);
    checkEq("keyCtl ready", rdVal[0], 32'h0);

    busWrite(keyCtlAddr, 32'h10);
    checkEq("irq", irq, 32'h0);
    // Release the keys for a fresh change
    keyN = '1;
    waitCtlBit(keyCtlAddr, 0, 3 * samplePeriod + 16, "key ready on release");
    checkEq("irq", irq, 32'h1);
    checkEq("intId", intId, 32'd2);

    // Timer takes priority over keys
    busWrite(timerCtlAddr, 32'h11);
    waitCtlBit(timerCtlAddr, 0, 40, "timer ready beside keys");
    checkEq("irq", irq, 32'h1);
    checkEq("intId", intId, 32'd1);

    $display("Checks run: %0d, errors: %0d, timeouts: %0d",
             checkCount, errCount, timeoutCount);
    if (errCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+sim
hw/ioTypesPkg.sv
hw/ioMapPkg.sv
hw/ioFabric.sv
hw/intervalTimer.sv
hw/keyDebouncer.sv
hw/displayRegs.sv
hw/ioSubsystem.sv
sim/ioSubsystemTb.sv
